//--- div_pkg.sv
// ----------------------------------------------------------
// Shared widths, defaults and control state encoding for the
// division unit; modules refer to these by scoped name
// ----------------------------------------------------------
`default_nettype none

package div_pkg;

  // Default operand width
  parameter int default_width = 8;

  // Request queue depth, also the request credits issued after reset
  parameter int default_fifo_depth = 4;

  // Response credits granted by the downstream after reset
  parameter int default_rsp_credits = 2;

  // Control sequencer states
  typedef enum logic [2:0] {
    st_idle    = 3'd0,
    st_prep    = 3'd1,
    st_iterate = 3'd2,
    st_fix     = 3'd3,
    st_hold    = 3'd4
  } ctrl_state_t;

endpackage

`default_nettype wire

//--- div_req_fifo.sv
// ----------------------------------------------------------
// Credit-managed request queue; the popped entry is held in
// head registers and every pop returns one request credit
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module div_req_fifo #(
  parameter int width      = div_pkg::default_width,
  parameter int fifo_depth = div_pkg::default_fifo_depth
) (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire logic             push,
  input  wire logic [width-1:0] push_dividend,
  input  wire logic [width-1:0] push_divisor,
  input  wire logic             pop,
  output logic      [width-1:0] head_dividend,
  output logic      [width-1:0] head_divisor,
  output logic                  empty,
  output logic                  credit_return
);

  localparam int aw = $clog2(fifo_depth);

  logic [width-1:0] mem_dividend [fifo_depth];
  logic [width-1:0] mem_divisor  [fifo_depth];

  // Extra pointer bit tells full from empty
  logic [aw:0] wr_ptr;
  logic [aw:0] rd_ptr;

  assign empty = (wr_ptr == rd_ptr);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      credit_return <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // One credit back per entry leaving the queue
      credit_return <= pop;
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem_dividend[wr_ptr[aw-1:0]] <= push_dividend;
      mem_divisor[wr_ptr[aw-1:0]]  <= push_divisor;
    end
    // Popped entry stays visible for the operand stage
    if (pop) begin
      head_dividend <= mem_dividend[rd_ptr[aw-1:0]];
      head_divisor  <= mem_divisor[rd_ptr[aw-1:0]];
    end
  end

endmodule

`default_nettype wire

//--- div_operand_prep.sv
// ----------------------------------------------------------
// Operand stage that registers magnitudes, result signs and
// the zero-divisor flag for one division
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module div_operand_prep #(
  parameter int width      = div_pkg::default_width,
  parameter bit signed_div = 1'b1
) (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire logic             load,
  input  wire logic [width-1:0] dividend,
  input  wire logic [width-1:0] divisor,
  output logic      [width-1:0] mag_dividend,
  output logic      [width-1:0] mag_divisor,
  output logic                  q_neg,
  output logic                  r_neg,
  output logic                  dz,
  output logic      [width-1:0] orig_dividend
);

  logic dvd_neg;
  logic dvs_neg;

  // Sign bits only count in signed mode
  assign dvd_neg = signed_div && dividend[width-1];
  assign dvs_neg = signed_div && divisor[width-1];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      q_neg <= 1'b0;
      r_neg <= 1'b0;
      dz    <= 1'b0;
    end else if (load) begin
      q_neg <= dvd_neg ^ dvs_neg;
      r_neg <= dvd_neg;
      dz    <= (divisor == '0);
    end
  end

  // Most negative value keeps its pattern and reads as an unsigned magnitude
  always_ff @(posedge clk) begin
    if (load) begin
      mag_dividend  <= dvd_neg ? -dividend : dividend;
      mag_divisor   <= dvs_neg ? -divisor : divisor;
      orig_dividend <= dividend;
    end
  end

endmodule

`default_nettype wire

//--- div_shift_sub.sv
// ----------------------------------------------------------
// Restoring shift-subtract core producing one quotient bit
// per step from the most significant dividend bit down
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module div_shift_sub #(
  parameter int width = div_pkg::default_width
) (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire logic             start,
  input  wire logic             step,
  input  wire logic [width-1:0] mag_dividend,
  input  wire logic [width-1:0] mag_divisor,
  output logic      [width-1:0] quot_mag,
  output logic      [width-1:0] rem_mag,
  output logic                  done
);

  localparam int cnt_w = $clog2(width + 1);
  localparam int idx_w = $clog2(width);

  // Step number in progress from 1 to width
  logic [cnt_w-1:0] count;
  logic [idx_w-1:0] bit_idx;
  logic             next_bit;
  logic [width:0]   shifted;
  logic [width:0]   diff;
  logic             fits;

  assign done     = (count == cnt_w'(width));
  assign bit_idx  = idx_w'(width - int'(count));
  assign next_bit = mag_dividend[bit_idx];

  // Trial subtraction on the widened partial remainder
  assign shifted = {rem_mag, next_bit};
  assign diff    = shifted - {1'b0, mag_divisor};
  assign fits    = (shifted >= {1'b0, mag_divisor});

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else if (start) begin
      count <= cnt_w'(1);
    end else if (step && !done) begin
      count <= count + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      rem_mag  <= '0;
      quot_mag <= '0;
    end else if (step) begin
      // Restore by keeping the shifted value when the divisor does not fit
      rem_mag  <= fits ? diff[width-1:0] : shifted[width-1:0];
      quot_mag <= {quot_mag[width-2:0], fits};
    end
  end

endmodule

`default_nettype wire

//--- div_result_fix.sv
// ----------------------------------------------------------
// Sign correction and divide-by-zero substitution; holds the
// response register until the next load
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module div_result_fix #(
  parameter int width = div_pkg::default_width
) (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire logic             load,
  input  wire logic [width-1:0] quot_mag,
  input  wire logic [width-1:0] rem_mag,
  input  wire logic             q_neg,
  input  wire logic             r_neg,
  input  wire logic             dz,
  input  wire logic [width-1:0] orig_dividend,
  output logic      [width-1:0] quotient,
  output logic      [width-1:0] remainder,
  output logic                  dz_out
);

  logic [width-1:0] quot_signed;
  logic [width-1:0] rem_signed;

  // A magnitude of 2**(width-1) negates to itself and gives the overflow result
  assign quot_signed = q_neg ? -quot_mag : quot_mag;
  assign rem_signed  = r_neg ? -rem_mag : rem_mag;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dz_out <= 1'b0;
    end else if (load) begin
      dz_out <= dz;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      // A zero divisor returns an all-ones quotient and the dividend as remainder
      quotient  <= dz ? '1 : quot_signed;
      remainder <= dz ? orig_dividend : rem_signed;
    end
  end

endmodule

`default_nettype wire

//--- div_ctrl.sv
// ----------------------------------------------------------
// Sequencer for one division at a time; also keeps the count
// of response credits granted by the downstream
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module div_ctrl #(
  parameter int rsp_credits = div_pkg::default_rsp_credits
) (
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic fifo_empty,
  input  wire logic core_done,
  input  wire logic rsp_credit,
  output logic      fifo_pop,
  output logic      prep_load,
  output logic      core_start,
  output logic      core_step,
  output logic      fix_load,
  output logic      rsp_valid
);

  localparam int cw = $clog2(rsp_credits + 1);

  div_pkg::ctrl_state_t state;
  div_pkg::ctrl_state_t state_nxt;

  logic [cw-1:0] credit_cnt;
  logic          credit_ok;

  assign credit_ok = (credit_cnt != '0);

  // Strobes decode straight from the state
  assign prep_load  = (state == div_pkg::st_prep);
  assign core_start = (state == div_pkg::st_prep);
  assign core_step  = (state == div_pkg::st_iterate);
  assign fix_load   = (state == div_pkg::st_fix);
  assign rsp_valid  = (state == div_pkg::st_hold) && credit_ok;

  // Next pop may overlap the response hand-off
  assign fifo_pop = !fifo_empty &&
                    ((state == div_pkg::st_idle) || rsp_valid);

  always_comb begin
    state_nxt = state;
    case (state)
      div_pkg::st_idle: begin
        if (fifo_pop) begin
          state_nxt = div_pkg::st_prep;
        end
      end
      div_pkg::st_prep: begin
        state_nxt = div_pkg::st_iterate;
      end
      div_pkg::st_iterate: begin
        if (core_done) begin
          state_nxt = div_pkg::st_fix;
        end
      end
      div_pkg::st_fix: begin
        state_nxt = div_pkg::st_hold;
      end
      div_pkg::st_hold: begin
        // Stay here with the result intact until a credit shows up
        if (rsp_valid) begin
          state_nxt = fifo_pop ? div_pkg::st_prep : div_pkg::st_idle;
        end
      end
      default: begin
        state_nxt = div_pkg::st_idle;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= div_pkg::st_idle;
    end else begin
      state <= state_nxt;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credit_cnt <= cw'(rsp_credits);
    end else begin
      case ({rsp_valid, rsp_credit})
        2'b10:   credit_cnt <= credit_cnt - 1'b1;
        2'b01:   credit_cnt <= credit_cnt + 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- div_unit_top.sv
// ----------------------------------------------------------
// Division unit top level with credit flow control on both
// the request and the response side
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module div_unit_top #(
  parameter int width       = div_pkg::default_width,
  parameter int fifo_depth  = div_pkg::default_fifo_depth,
  parameter int rsp_credits = div_pkg::default_rsp_credits,
  parameter bit signed_div  = 1'b1
) (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire logic             req_valid,
  input  wire logic [width-1:0] req_dividend,
  input  wire logic [width-1:0] req_divisor,
  input  wire logic             rsp_credit,
  output logic                  req_credit,
  output logic                  rsp_valid,
  output logic      [width-1:0] rsp_quotient,
  output logic      [width-1:0] rsp_remainder,
  output logic                  rsp_dz
);

  logic [width-1:0] head_dividend;
  logic [width-1:0] head_divisor;
  logic             fifo_empty;
  logic             fifo_pop;
  logic             prep_load;
  logic             core_start;
  logic             core_step;
  logic             core_done;
  logic             fix_load;
  logic [width-1:0] mag_dividend;
  logic [width-1:0] mag_divisor;
  logic             q_neg;
  logic             r_neg;
  logic             dz;
  logic [width-1:0] orig_dividend;
  logic [width-1:0] quot_mag;
  logic [width-1:0] rem_mag;

  div_req_fifo #(.width(width), .fifo_depth(fifo_depth)) u_fifo (
    .clk(clk), .rst_n(rst_n),
    .push(req_valid), .push_dividend(req_dividend), .push_divisor(req_divisor),
    .pop(fifo_pop), .head_dividend(head_dividend), .head_divisor(head_divisor),
    .empty(fifo_empty), .credit_return(req_credit)
  );

  div_operand_prep #(.width(width), .signed_div(signed_div)) u_prep (
    .clk(clk), .rst_n(rst_n), .load(prep_load),
    .dividend(head_dividend), .divisor(head_divisor),
    .mag_dividend(mag_dividend), .mag_divisor(mag_divisor),
    .q_neg(q_neg), .r_neg(r_neg), .dz(dz), .orig_dividend(orig_dividend)
  );

  div_shift_sub #(.width(width)) u_core (
    .clk(clk), .rst_n(rst_n), .start(core_start), .step(core_step),
    .mag_dividend(mag_dividend), .mag_divisor(mag_divisor),
    .quot_mag(quot_mag), .rem_mag(rem_mag), .done(core_done)
  );

  div_result_fix #(.width(width)) u_fix (
    .clk(clk), .rst_n(rst_n), .load(fix_load),
    .quot_mag(quot_mag), .rem_mag(rem_mag),
    .q_neg(q_neg), .r_neg(r_neg), .dz(dz), .orig_dividend(orig_dividend),
    .quotient(rsp_quotient), .remainder(rsp_remainder), .dz_out(rsp_dz)
  );

  div_ctrl #(.rsp_credits(rsp_credits)) u_ctrl (
    .clk(clk), .rst_n(rst_n),
    .fifo_empty(fifo_empty), .core_done(core_done), .rsp_credit(rsp_credit),
    .fifo_pop(fifo_pop), .prep_load(prep_load), .core_start(core_start),
    .core_step(core_step), .fix_load(fix_load), .rsp_valid(rsp_valid)
  );

endmodule

`default_nettype wire

//--- tb_div_checker.sv
// ----------------------------------------------------------
// Response checker for the division unit; asserts the result
// rules on every response against the operands sent for it
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tb_div_checker #(
  parameter int width = 8
) (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire logic             rsp_valid,
  input  wire logic [width-1:0] rsp_quotient,
  input  wire logic [width-1:0] rsp_remainder,
  input  wire logic             rsp_dz,
  input  wire logic [width-1:0] exp_dividend,
  input  wire logic [width-1:0] exp_divisor,
  output logic                  err
);

  localparam int min_val = -(1 << (width - 1));

  logic err_q = 1'b0;
  int   dvd;
  int   dvs;
  int   q;
  int   r;
  int   eq;
  int   er;

  assign err = err_q;

  function automatic int absval(input int v);
    return (v < 0) ? -v : v;
  endfunction

  task automatic report(input string name, input int exp_v, input int act_v);
    $display("FAIL %s expected %0d actual %0d", name, exp_v, act_v);
    err_q = 1'b1;
  endtask

  // Outputs are stable mid-cycle, so sample on the falling edge
  always @(negedge clk) begin
    if (rst_n && rsp_valid) begin
      dvd = int'($signed(exp_dividend));
      dvs = int'($signed(exp_divisor));
      q   = int'($signed(rsp_quotient));
      r   = int'($signed(rsp_remainder));
      if (dvs == 0) begin
        eq = -1;
        er = dvd;
      end else if (dvd == min_val && dvs == -1) begin
        eq = min_val;
        er = 0;
      end else begin
        // Truncating division of the widened operands
        eq = dvd / dvs;
        er = dvd % dvs;
      end
      assert (rsp_dz == (dvs == 0)) else report("dz flag", int'(dvs == 0), int'(rsp_dz));
      assert (rsp_quotient == width'(eq)) else report("quotient", eq, q);
      assert (rsp_remainder == width'(er)) else report("remainder", er, r);
      if (dvs != 0 && !(dvd == min_val && dvs == -1)) begin
        assert (q * dvs + r == dvd) else report("identity", dvd, q * dvs + r);
        assert (absval(r) < absval(dvs)) else report("remainder bound", absval(dvs), absval(r));
        assert (r == 0 || ((r < 0) == (dvd < 0)))
          else report("remainder sign", int'(dvd < 0), int'(r < 0));
        assert (q == 0 || ((q < 0) == ((dvd < 0) ^ (dvs < 0))))
          else report("quotient sign", int'((dvd < 0) ^ (dvs < 0)), int'(q < 0));
      end
    end
  end

endmodule

`default_nettype wire

//--- tb_div_unit.sv
// ----------------------------------------------------------
// Testbench top for the division unit with credit handling
// on both sides, xorshift stimulus and an in-order scoreboard
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tb_div_unit;

  localparam int width       = 8;
  localparam int fifo_depth  = 4;
  localparam int rsp_credits = 2;
  localparam int max_cycles  = 3000;

  logic             clk;
  logic             rst_n;
  logic             req_valid;
  logic [width-1:0] req_dividend;
  logic [width-1:0] req_divisor;
  logic             rsp_credit;
  logic             req_credit;
  logic             rsp_valid;
  logic [width-1:0] rsp_quotient;
  logic [width-1:0] rsp_remainder;
  logic             rsp_dz;
  logic             chk_err;

  // Sent operands in request order and indexed by response count
  logic [width-1:0] sent_dvd [256];
  logic [width-1:0] sent_dvs [256];
  int               sent_cnt = 0;
  int               credit_back = 0;
  int               rsp_count = 0;
  int               credits_given = 0;
  int               base;
  logic             hold_credits;
  logic [31:0]      stim_state;
  logic [31:0]      delay_state;

  div_unit_top #(
    .width(width), .fifo_depth(fifo_depth), .rsp_credits(rsp_credits), .signed_div(1'b1)
  ) dut0 (
    .clk(clk), .rst_n(rst_n), .req_valid(req_valid),
    .req_dividend(req_dividend), .req_divisor(req_divisor), .rsp_credit(rsp_credit),
    .req_credit(req_credit), .rsp_valid(rsp_valid), .rsp_quotient(rsp_quotient),
    .rsp_remainder(rsp_remainder), .rsp_dz(rsp_dz)
  );

  tb_div_checker #(.width(width)) checker0 (
    .clk(clk), .rst_n(rst_n), .rsp_valid(rsp_valid), .rsp_quotient(rsp_quotient),
    .rsp_remainder(rsp_remainder), .rsp_dz(rsp_dz),
    .exp_dividend(sent_dvd[8'(rsp_count)]), .exp_divisor(sent_dvs[8'(rsp_count)]),
    .err(chk_err)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic stop_with_fail(input string text);
    $display("%s", text);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge chk_err) begin
    stop_with_fail("Response checker found a wrong result");
  end

  // Credit accounting on both sides
  always @(posedge clk) begin
    if (rst_n) begin
      if (req_credit) begin
        credit_back = credit_back + 1;
        assert (credit_back <= sent_cnt)
          else stop_with_fail($sformatf("FAIL req_credit count expected %0d actual %0d",
                                        sent_cnt, credit_back));
      end
      if (rsp_valid) begin
        rsp_count = rsp_count + 1;
        assert (rsp_count - credits_given <= rsp_credits)
          else stop_with_fail($sformatf("FAIL rsp credit use expected %0d actual %0d",
                                        rsp_credits, rsp_count - credits_given));
      end
    end
  end

  // Downstream frees slots after a random delay unless it is holding back
  initial begin
    rsp_credit = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      rsp_credit = 1'b0;
      delay_state = xorshift32(delay_state);
      if (!hold_credits && rsp_count > credits_given && delay_state[1:0] == 2'd0) begin
        rsp_credit = 1'b1;
        credits_given = credits_given + 1;
      end
    end
  end

  task automatic send_req(input logic [width-1:0] dvd, input logic [width-1:0] dvs);
    int n;
    n = 0;
    @(posedge clk);
    #1;
    while (sent_cnt - credit_back >= fifo_depth) begin
      n = n + 1;
      if (n > max_cycles) begin
        stop_with_fail("Timed out waiting for a request credit");
      end
      @(posedge clk);
      #1;
    end
    sent_dvd[8'(sent_cnt)] = dvd;
    sent_dvs[8'(sent_cnt)] = dvs;
    req_dividend = dvd;
    req_divisor  = dvs;
    req_valid    = 1'b1;
    sent_cnt     = sent_cnt + 1;
    @(posedge clk);
    #1;
    req_valid = 1'b0;
  endtask

  task automatic drain;
    int n;
    n = 0;
    while (rsp_count != sent_cnt || credits_given != rsp_count) begin
      n = n + 1;
      if (n > max_cycles) begin
        stop_with_fail("Timed out waiting for responses to drain");
      end
      @(negedge clk);
    end
  endtask

  task automatic check_count(input string name, input int exp_v, input int act_v);
    assert (exp_v == act_v)
      else stop_with_fail($sformatf("FAIL %s expected %0d actual %0d", name, exp_v, act_v));
  endtask

  initial begin
    rst_n        = 1'b0;
    req_valid    = 1'b0;
    req_dividend = '0;
    req_divisor  = '0;
    hold_credits = 1'b0;
    stim_state   = 32'haddd5bf6;
    delay_state  = ~32'haddd5bf6;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // Idle after reset gives no responses and no stray credits
    repeat (10) begin
      @(posedge clk);
      #1;
      check_count("idle rsp_valid", 0, int'(rsp_valid));
    end
    check_count("idle req_credit", 0, credit_back);

    // Special operands over all sign combinations
    send_req(8'sd0, 8'sd5);
    send_req(8'sd0, -8'sd3);
    send_req(8'sd7, 8'sd1);
    send_req(-8'sd7, 8'sd1);
    send_req(8'h80, 8'hff);
    send_req(8'h80, 8'sd1);
    send_req(8'sd127, -8'sd1);
    send_req(8'h80, 8'sd127);
    send_req(8'sd17, 8'sd5);
    send_req(-8'sd17, 8'sd5);
    send_req(8'sd17, -8'sd5);
    send_req(-8'sd17, -8'sd5);
    // Zero divisors
    send_req(8'sd45, 8'sd0);
    send_req(-8'sd45, 8'sd0);
    send_req(8'sd0, 8'sd0);
    drain();

    // Random operands with the divisor forced nonzero
    repeat (60) begin
      stim_state = xorshift32(stim_state);
      send_req(stim_state[7:0], (stim_state[15:8] == 8'd0) ? 8'd3 : stim_state[15:8]);
    end
    drain();

    // Held credits let two responses out while the third waits in hold and the queue fills
    @(negedge clk);
    hold_credits = 1'b1;
    base = rsp_count;
    repeat (7) begin
      stim_state = xorshift32(stim_state);
      send_req(stim_state[7:0], stim_state[15:8] | 8'd1);
    end
    repeat (50) @(posedge clk);
    check_count("stalled responses", base + rsp_credits, rsp_count);
    check_count("outstanding requests", fifo_depth, sent_cnt - credit_back);
    @(negedge clk);
    hold_credits = 1'b0;
    drain();

    check_count("total req_credit", sent_cnt, credit_back);
    if (chk_err) begin
      $display("Simulation finished: FAIL");
      $fatal(1);
    end else begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- sim.f
div_pkg.sv
div_req_fifo.sv
div_operand_prep.sv
div_shift_sub.sv
div_result_fix.sv
div_ctrl.sv
div_unit_top.sv
tb_div_checker.sv
tb_div_unit.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= tb_div_unit
FILELIST  ?= sim.f
PASS_MSG  := Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

obj_dir/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

test: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
